// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_axi_ctrl_logic \
    -f verilog.f \
    && ./obj_dir/Vtb_axi_ctrl_logic > sim.log 2>&1 \
    || echo "build or simulation did not complete" >> sim.log

cat sim.log
grep -qx "TESTBENCH PASSED" sim.log && exit 0 || exit 1

// ==== source/axi_ctrl_logic.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_ctrl_logic #(
    parameter int ls_depth = axi_ctrl_pkg::fifo_depth_default,
    parameter int ss_depth = axi_ctrl_pkg::fifo_depth_default
) (
    input  wire                                axi_aclk,
    input  wire                                axi_aresetn,
    // local register port
    input  wire axi_ctrl_pkg::local_req_t      local_req,
    input  wire                                local_valid,
    output logic                               local_ready,
    // remote stream port
    input  wire axi_ctrl_pkg::stream_word_t    remote_word,
    input  wire                                remote_valid,
    output logic                               remote_ready,
    // read response and interrupt
    output logic [axi_ctrl_pkg::data_w-1:0]    read_data,
    output logic                               read_done,
    output logic                               axi_interrupt
);

    import axi_ctrl_pkg::*;

    // local queue to sequencer
    local_req_t   ls_item;
    logic         ls_valid;
    logic         ls_ready;
    // remote queue to assembler
    stream_word_t ss_item;
    logic         ss_valid;
    logic         ss_ready;
    // assembler to sequencer
    remote_wr_t   pair;
    logic         pair_valid;
    logic         pair_ready;
    // sequencer to bank
    bank_cmd_t    cmd;
    logic         cmd_valid;

    //////////////////////////////////////////////////////////////////////
    // input queues
    //////////////////////////////////////////////////////////////////////

    ctrl_fifo #(
        .WIDTH($bits(local_req_t)),
        .DEPTH(ls_depth)
    ) i_ls_fifo (
        .axi_aclk   (axi_aclk),
        .axi_aresetn(axi_aresetn),
        .in_data    (local_req),
        .in_valid   (local_valid),
        .in_ready   (local_ready),
        .out_data   (ls_item),
        .out_valid  (ls_valid),
        .out_ready  (ls_ready)
    );

    ctrl_fifo #(
        .WIDTH($bits(stream_word_t)),
        .DEPTH(ss_depth)
    ) i_ss_fifo (
        .axi_aclk   (axi_aclk),
        .axi_aresetn(axi_aresetn),
        .in_data    (remote_word),
        .in_valid   (remote_valid),
        .in_ready   (remote_ready),
        .out_data   (ss_item),
        .out_valid  (ss_valid),
        .out_ready  (ss_ready)
    );

    //////////////////////////////////////////////////////////////////////
    // pairing, sequencing, registers
    //////////////////////////////////////////////////////////////////////

    remote_pair_assembler i_pair_asm (
        .axi_aclk   (axi_aclk),
        .axi_aresetn(axi_aresetn),
        .word       (ss_item),
        .word_valid (ss_valid),
        .word_ready (ss_ready),
        .pair       (pair),
        .pair_valid (pair_valid),
        .pair_ready (pair_ready)
    );

    ctrl_sequencer i_seq (
        .axi_aclk   (axi_aclk),
        .axi_aresetn(axi_aresetn),
        .ls_item    (ls_item),
        .ls_valid   (ls_valid),
        .ls_ready   (ls_ready),
        .pair       (pair),
        .pair_valid (pair_valid),
        .pair_ready (pair_ready),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid)
    );

    ctrl_register_bank i_bank (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .read_data    (read_data),
        .read_done    (read_done),
        .axi_interrupt(axi_interrupt)
    );

endmodule

`default_nettype wire

// ==== source/axi_ctrl_pkg.sv ====
`default_nettype none

package axi_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    // local register port byte address
    localparam int addr_w = 15;
    localparam int data_w = 32;
    localparam int strb_w = 4;
    localparam int user_w = 2;
    // address field carried in a remote header word
    localparam int raddr_w = 28;

    //////////////////////////////////////////////////////////////////////
    // address map
    //////////////////////////////////////////////////////////////////////

    // mailbox bank, eight words
    localparam logic [addr_w-1:0] mb_low  = 15'h2000;
    localparam logic [addr_w-1:0] mb_high = 15'h201F;
    // control bank, two words
    localparam logic [addr_w-1:0] aa_low  = 15'h2100;
    localparam logic [addr_w-1:0] aa_high = 15'h2107;

    localparam int mb_words = 8;
    localparam int aa_words = 2;
    // word index into the larger bank
    localparam int idx_w = $clog2(mb_words);

    localparam int fifo_depth_default = 8;

    //////////////////////////////////////////////////////////////////////
    // enums
    //////////////////////////////////////////////////////////////////////

    typedef enum logic {req_write, req_read} req_kind_e;

    // only user_remote_write is acted on
    typedef enum logic [user_w-1:0] {
        user_none         = 2'b00,
        user_remote_write = 2'b01,
        user_addr         = 2'b10,
        user_data         = 2'b11
    } user_code_e;

    typedef enum logic [1:0] {st_wait, st_decide, st_execute} seq_state_e;

    typedef enum logic [1:0] {tgt_mailbox, tgt_control, tgt_none} target_e;

    //////////////////////////////////////////////////////////////////////
    // packed structs
    //////////////////////////////////////////////////////////////////////

    // local request, 52 bits
    typedef struct packed {
        req_kind_e           kind;
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   data;
        logic [strb_w-1:0]   strb;
    } local_req_t;

    // remote stream word, 34 bits
    typedef struct packed {
        logic [data_w-1:0]   data;
        user_code_e          user;
    } stream_word_t;

    // header and data word joined, 64 bits
    typedef struct packed {
        logic [strb_w-1:0]   strb;
        logic [raddr_w-1:0]  addr;
        logic [data_w-1:0]   data;
    } remote_wr_t;

    // one decoded access for the register bank
    typedef struct packed {
        logic                write;
        logic                read;
        target_e             target;
        logic [idx_w-1:0]    index;
        logic [data_w-1:0]   data;
        logic [strb_w-1:0]   strb;
        logic                remote;
    } bank_cmd_t;

endpackage

`default_nettype wire

// ==== source/ctrl_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  wire              axi_aclk,
    input  wire              axi_aresetn,
    input  wire [WIDTH-1:0]  in_data,
    input  wire              in_valid,
    output logic             in_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  wire              out_ready
);

    localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cnt_w = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] count_next;
    logic             push;
    logic             pop;

    // pointer wrap, depth need not be a power of two
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // head entry straight from storage
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign count_next = count + cnt_w'(push) - cnt_w'(pop);

    // storage
    always_ff @(posedge axi_aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers, count and registered ready
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            // held low through reset
            in_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count    <= count_next;
            // full queue pushes back on the sender
            in_ready <= (count_next != cnt_w'(DEPTH));
        end
    end

endmodule

`default_nettype wire

// ==== source/ctrl_register_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_register_bank (
    input  wire                                 axi_aclk,
    input  wire                                 axi_aresetn,
    input  wire axi_ctrl_pkg::bank_cmd_t        cmd,
    input  wire                                 cmd_valid,
    output logic [axi_ctrl_pkg::data_w-1:0]     read_data,
    output logic                                read_done,
    output logic                                axi_interrupt
);

    import axi_ctrl_pkg::*;

    localparam int aa_idx_w = (aa_words > 1) ? $clog2(aa_words) : 1;

    logic [data_w-1:0]   mb_regs [mb_words];
    logic [data_w-1:0]   aa_regs [aa_words];
    logic [aa_idx_w-1:0] aa_idx;
    logic [data_w-1:0]   rd_word;
    logic                do_write;

    // byte lane merge under strobe
    function automatic logic [data_w-1:0] strb_merge(
        input logic [data_w-1:0] old_word,
        input logic [data_w-1:0] new_word,
        input logic [strb_w-1:0] strb
    );
        logic [data_w-1:0] merged;
        merged = old_word;
        for (int b = 0; b < strb_w; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    assign aa_idx   = cmd.index[aa_idx_w-1:0];
    assign do_write = cmd_valid && cmd.write;

    // unmapped reads give zero
    always_comb begin
        case (cmd.target)
            tgt_mailbox: rd_word = mb_regs[cmd.index];
            tgt_control: rd_word = aa_regs[aa_idx];
            default:     rd_word = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // registers and response pulses
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            for (int i = 0; i < mb_words; i++) begin
                mb_regs[i] <= '0;
            end
            for (int i = 0; i < aa_words; i++) begin
                aa_regs[i] <= '0;
            end
            read_done     <= 1'b0;
            axi_interrupt <= 1'b0;
        end else begin
            if (do_write && cmd.target == tgt_mailbox) begin
                mb_regs[cmd.index] <= strb_merge(mb_regs[cmd.index], cmd.data, cmd.strb);
            end
            if (do_write && cmd.target == tgt_control) begin
                aa_regs[aa_idx] <= strb_merge(aa_regs[aa_idx], cmd.data, cmd.strb);
            end
            // one cycle after the command
            read_done     <= cmd_valid && cmd.read;
            axi_interrupt <= do_write && cmd.remote && (cmd.target == tgt_mailbox);
        end
    end

    // read word lands with read_done
    always_ff @(posedge axi_aclk) begin
        if (cmd_valid && cmd.read) begin
            read_data <= rd_word;
        end
    end

endmodule

`default_nettype wire

// ==== source/ctrl_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_sequencer (
    input  wire                            axi_aclk,
    input  wire                            axi_aresetn,
    input  wire axi_ctrl_pkg::local_req_t  ls_item,
    input  wire                            ls_valid,
    output logic                           ls_ready,
    input  wire axi_ctrl_pkg::remote_wr_t  pair,
    input  wire                            pair_valid,
    output logic                           pair_ready,
    output axi_ctrl_pkg::bank_cmd_t        cmd,
    output logic                           cmd_valid
);

    import axi_ctrl_pkg::*;

    seq_state_e          state;
    seq_state_e          state_next;
    // source chosen in st_wait, 1 for remote
    logic                sel_remote;
    logic                last_remote;
    logic                pick_remote;
    logic [raddr_w-1:0]  dec_addr;
    logic                in_mb;
    logic                in_aa;
    bank_cmd_t           cmd_d;
    bank_cmd_t           cmd_q;

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            st_wait: begin
                if (ls_valid || pair_valid) begin
                    state_next = st_decide;
                end
            end
            st_decide:  state_next = st_execute;
            st_execute: state_next = st_wait;
            default:    state_next = st_wait;
        endcase
    end

    // round robin, only a tie looks at the last source
    assign pick_remote = pair_valid && !(ls_valid && last_remote);

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            state       <= st_wait;
            sel_remote  <= 1'b0;
            // local wins the first tie
            last_remote <= 1'b1;
        end else begin
            state <= state_next;
            if (state == st_wait) begin
                sel_remote <= pick_remote;
            end
            if (state == st_execute) begin
                last_remote <= sel_remote;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////////////

    assign dec_addr = sel_remote ? pair.addr : raddr_w'(ls_item.addr);
    assign in_mb = (dec_addr >= raddr_w'(mb_low)) && (dec_addr <= raddr_w'(mb_high));
    assign in_aa = (dec_addr >= raddr_w'(aa_low)) && (dec_addr <= raddr_w'(aa_high));

    always_comb begin
        // both banks sit on 32 byte boundaries
        cmd_d.index  = dec_addr[idx_w+1:2];
        cmd_d.remote = sel_remote;
        if (sel_remote) begin
            // remote side may only touch the mailbox
            cmd_d.write  = 1'b1;
            cmd_d.read   = 1'b0;
            cmd_d.target = in_mb ? tgt_mailbox : tgt_none;
            cmd_d.data   = pair.data;
            cmd_d.strb   = pair.strb;
        end else begin
            cmd_d.write  = (ls_item.kind == req_write);
            cmd_d.read   = (ls_item.kind == req_read);
            cmd_d.target = in_mb ? tgt_mailbox : (in_aa ? tgt_control : tgt_none);
            cmd_d.data   = ls_item.data;
            cmd_d.strb   = ls_item.strb;
        end
    end

    // decoded command held for st_execute
    always_ff @(posedge axi_aclk) begin
        if (state == st_decide) begin
            cmd_q <= cmd_d;
        end
    end

    // issue and pop together
    assign cmd        = cmd_q;
    assign cmd_valid  = (state == st_execute);
    assign ls_ready   = (state == st_execute) && !sel_remote;
    assign pair_ready = (state == st_execute) && sel_remote;

endmodule

`default_nettype wire

// ==== source/remote_pair_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module remote_pair_assembler (
    input  wire                              axi_aclk,
    input  wire                              axi_aresetn,
    input  wire axi_ctrl_pkg::stream_word_t  word,
    input  wire                              word_valid,
    output logic                             word_ready,
    output axi_ctrl_pkg::remote_wr_t         pair,
    output logic                             pair_valid,
    input  wire                              pair_ready
);

    import axi_ctrl_pkg::*;

    // held header word
    logic [data_w-1:0] hdr;
    logic              hdr_held;
    logic              is_rw;
    logic              take;

    assign is_rw = (word.user == user_remote_write);

    //////////////////////////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////////////////////////

    // second write word stays at the head until the pair goes
    assign pair_valid = word_valid && is_rw && hdr_held;

    // other user codes drain in one cycle
    assign word_ready = !is_rw || !hdr_held || pair_ready;

    assign take = word_valid && word_ready;

    // header holds strobe on top and address below
    always_comb begin
        pair.strb = hdr[data_w-1 -: strb_w];
        pair.addr = hdr[raddr_w-1:0];
        pair.data = word.data;
    end

    //////////////////////////////////////////////////////////////////////
    // header capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge axi_aclk) begin
        if (take && is_rw && !hdr_held) begin
            hdr <= word.data;
        end
    end

    // flag set by the header, cleared when the pair is taken
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            hdr_held <= 1'b0;
        end else if (take && is_rw) begin
            hdr_held <= !hdr_held;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_axi_ctrl_logic.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_ctrl_logic;

    import axi_ctrl_pkg::*;

    localparam int ls_depth      = 8;
    localparam int ss_depth      = 8;
    localparam int settle_cycles = 10;
    // budgets are items times cycles per item
    localparam int item_cycles   = 20;
    localparam int budget_reset  = 8 + 10 * item_cycles;
    localparam int budget_ctrl   = 24 * item_cycles;
    localparam int budget_mbox   = 28 * item_cycles;
    localparam int budget_remote = 16 * item_cycles;
    localparam int budget_drop   = 20 * item_cycles;
    localparam int budget_burst  = 34 * item_cycles;
    localparam int cycle_limit   = 2 * (budget_reset + budget_ctrl + budget_mbox
                                        + budget_remote + budget_drop + budget_burst);

    logic              axi_aclk;
    logic              axi_aresetn;
    local_req_t        local_req;
    logic              local_valid;
    logic              local_ready;
    stream_word_t      remote_word;
    logic              remote_valid;
    logic              remote_ready;
    logic [data_w-1:0] read_data;
    logic              read_done;
    logic              axi_interrupt;

    // reference model state
    logic [data_w-1:0] mb_model [mb_words];
    logic [data_w-1:0] aa_model [aa_words];
    // expected read data in issue order
    logic [data_w-1:0] exp_reads [1024];
    int rd_exp     = 0;
    int irq_exp    = 0;
    int rd_count   = 0;
    int irq_count  = 0;
    int seq_errors = 0;
    int mon_errors = 0;
    int cycles     = 0;
    int stalls     = 0;
    logic [31:0] rng;

    axi_ctrl_logic #(
        .ls_depth(ls_depth),
        .ss_depth(ss_depth)
    ) i_axi_ctrl_logic (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .local_req    (local_req),
        .local_valid  (local_valid),
        .local_ready  (local_ready),
        .remote_word  (remote_word),
        .remote_valid (remote_valid),
        .remote_ready (remote_ready),
        .read_data    (read_data),
        .read_done    (read_done),
        .axi_interrupt(axi_interrupt)
    );

    // 100 ns period
    always #50 axi_aclk = ~axi_aclk;

    //////////////////////////////////////////////////////////////////////
    // response monitor sampled mid cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge axi_aclk) begin
        if (!axi_aresetn) begin
            assert ({read_done, axi_interrupt, local_ready, remote_ready} == 4'h0) else begin
                $display("CHECK FAILED read_done/axi_interrupt/local_ready/remote_ready: %h %h",
                         {read_done, axi_interrupt, local_ready, remote_ready}, 4'h0);
                mon_errors++;
            end
        end else begin
            if (read_done) begin
                assert (rd_count < rd_exp) else begin
                    $display("read_done pulsed with no read outstanding");
                    mon_errors++;
                end
                if (rd_count < rd_exp) begin
                    assert (read_data === exp_reads[rd_count]) else begin
                        $display("CHECK FAILED read_data: got %h expected %h",
                                 read_data, exp_reads[rd_count]);
                        mon_errors++;
                    end
                end
                rd_count++;
            end
            if (axi_interrupt) begin
                irq_count++;
            end
        end
    end

    // run limit
    always @(posedge axi_aclk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout, run passed %0d cycles", cycle_limit);
            $display("errors: %0d check failures, %0d response failures",
                     seq_errors, mon_errors);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // random numbers and reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(output logic [31:0] value);
        rng   = xorshift32(rng);
        value = rng;
    endtask

    // one byte of ones per set strobe bit
    function automatic logic [data_w-1:0] lane_mask(input logic [strb_w-1:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    function automatic logic in_range(input logic [27:0] addr,
                                      input logic [addr_w-1:0] lo,
                                      input logic [addr_w-1:0] hi);
        return (addr >= 28'(lo)) && (addr <= 28'(hi));
    endfunction

    // both windows start 32 byte aligned so the word index is addr[4:2]
    task automatic model_write(input logic [27:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        logic [31:0] m;
        m = lane_mask(strb);
        if (in_range(addr, mb_low, mb_high)) begin
            mb_model[addr[4:2]] = (mb_model[addr[4:2]] & ~m) | (data & m);
        end else if (in_range(addr, aa_low, aa_high)) begin
            aa_model[addr[2]] = (aa_model[addr[2]] & ~m) | (data & m);
        end
    endtask

    function automatic logic [data_w-1:0] model_read(input logic [27:0] addr);
        if (in_range(addr, mb_low, mb_high)) begin
            return mb_model[addr[4:2]];
        end
        if (in_range(addr, aa_low, aa_high)) begin
            return aa_model[addr[2]];
        end
        // unmapped space reads as zero
        return '0;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // drivers entered and left 1 ns after a rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic settle;
        repeat (settle_cycles) @(posedge axi_aclk);
        #1;
    endtask

    task automatic wait_reads;
        while (rd_count < rd_exp) begin
            @(posedge axi_aclk);
            #1;
        end
    endtask

    task automatic push_local(input local_req_t req);
        logic accepted;
        accepted    = 1'b0;
        local_req   = req;
        local_valid = 1'b1;
        while (!accepted) begin
            @(negedge axi_aclk);
            if (local_ready) begin
                accepted = 1'b1;
            end else begin
                stalls++;
            end
            @(posedge axi_aclk);
            #1;
        end
        local_valid = 1'b0;
        // model follows the handshake order
        if (req.kind == req_read) begin
            exp_reads[rd_exp] = model_read(28'(req.addr));
            rd_exp++;
        end else begin
            model_write(28'(req.addr), req.data, req.strb);
        end
    endtask

    task automatic push_remote(input stream_word_t word);
        logic accepted;
        accepted     = 1'b0;
        remote_word  = word;
        remote_valid = 1'b1;
        while (!accepted) begin
            @(negedge axi_aclk);
            accepted = remote_ready;
            @(posedge axi_aclk);
            #1;
        end
        remote_valid = 1'b0;
    endtask

    task automatic local_write(input logic [14:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        local_req_t req;
        req.kind = req_write;
        req.addr = addr;
        req.data = data;
        req.strb = strb;
        push_local(req);
        settle();
    endtask

    task automatic local_read(input logic [14:0] addr);
        local_req_t req;
        req.kind = req_read;
        req.addr = addr;
        req.data = '0;
        req.strb = '0;
        push_local(req);
        wait_reads();
    endtask

    task automatic check_irq;
        assert (irq_count == irq_exp) else begin
            $display("CHECK FAILED axi_interrupt pulses: got %h expected %h",
                     irq_count, irq_exp);
            seq_errors++;
        end
    endtask

    // header then data word tagged as a remote write
    task automatic remote_pair(input logic [27:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        stream_word_t w;
        w.user = user_remote_write;
        w.data = {strb, addr};
        push_remote(w);
        w.data = data;
        push_remote(w);
        if (in_range(addr, mb_low, mb_high)) begin
            model_write(addr, data, strb);
            irq_exp++;
        end
        settle();
        check_irq();
    endtask

    task automatic read_all_regs;
        for (int i = 0; i < mb_words; i++) begin
            local_read(mb_low + 15'(4 * i));
        end
        for (int i = 0; i < aa_words; i++) begin
            local_read(aa_low + 15'(4 * i));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]  r;
        logic [31:0]  d;
        logic [14:0]  a;
        local_req_t   req;
        stream_word_t w;
        axi_aclk     = 1'b0;
        axi_aresetn  = 1'b0;
        local_req    = '0;
        local_valid  = 1'b0;
        remote_word  = '0;
        remote_valid = 1'b0;
        rng          = 32'h8c97bd93;
        for (int i = 0; i < mb_words; i++) begin
            mb_model[i] = '0;
        end
        for (int i = 0; i < aa_words; i++) begin
            aa_model[i] = '0;
        end
        repeat (8) @(posedge axi_aclk);
        #1;
        axi_aresetn = 1'b1;
        @(posedge axi_aclk);
        #1;

        // everything reads zero after reset with no stray pulses
        read_all_regs();
        check_irq();

        // byte merge into control words under random strobes
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < aa_words; i++) begin
                a = aa_low + 15'(4 * i);
                local_read(a);
                draw(d);
                draw(r);
                local_write(a, d, r[3:0]);
                local_read(a);
            end
        end

        // full mailbox write and read back
        for (int i = 0; i < mb_words; i++) begin
            draw(d);
            local_write(mb_low + 15'(4 * i), d, 4'hF);
        end
        for (int i = 0; i < mb_words; i++) begin
            local_read(mb_low + 15'(4 * i));
        end
        // unmapped space above the mailbox and in the user window
        for (int i = 0; i < 6; i++) begin
            draw(r);
            a = 15'h2020 + 15'(r % 32'hFE0);
            if (in_range(28'(a), aa_low, aa_high)) begin
                a = a + 15'h8;
            end
            local_read(a);
            draw(r);
            if (i % 2 == 0) begin
                local_read(15'h3000 + 15'(r % 32'h5000));
            end else begin
                local_read({2'b00, r[12:0]});
            end
        end

        // remote writes into the mailbox
        for (int i = 0; i < mb_words; i++) begin
            draw(d);
            draw(r);
            remote_pair(28'(mb_low) + 28'(4 * i), d, r[3:0]);
            local_read(mb_low + 15'(4 * i));
        end

        // remote writes outside the mailbox are dropped
        draw(d);
        remote_pair(28'(aa_low), d, 4'hF);
        draw(d);
        remote_pair(28'(aa_low) + 28'h4, d, 4'hF);
        draw(d);
        remote_pair(28'h0010000 | 28'(mb_low), d, 4'hF);
        // other user codes with some shaped like mailbox headers
        for (int i = 0; i < 6; i++) begin
            draw(r);
            w.data = (i % 2 == 0) ? {4'hF, 28'(mb_low)} : r;
            case (i % 3)
                0:       w.user = user_none;
                1:       w.user = user_addr;
                default: w.user = user_data;
            endcase
            push_remote(w);
        end
        settle();
        check_irq();
        read_all_regs();

        // local burst past the queue depth with the remote side idle
        stalls = 0;
        for (int i = 0; i < 3 * ls_depth; i++) begin
            draw(r);
            draw(d);
            req.kind = r[31] ? req_read : req_write;
            req.addr = r[8] ? (aa_low + 15'({r[2], 2'b00}))
                            : (mb_low + 15'({r[4:2], 2'b00}));
            req.data = d;
            req.strb = r[19:16];
            push_local(req);
        end
        wait_reads();
        settle();
        assert (stalls > 0) else begin
            $display("local_ready never dropped during the local burst");
            seq_errors++;
        end
        read_all_regs();

        // final accounting
        settle();
        assert (rd_count == rd_exp) else begin
            $display("CHECK FAILED read_done count: got %h expected %h", rd_count, rd_exp);
            seq_errors++;
        end
        check_irq();
        $display("errors: %0d check failures, %0d response failures", seq_errors, mon_errors);
        if (seq_errors == 0 && mon_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/axi_ctrl_pkg.sv
source/ctrl_fifo.sv
source/remote_pair_assembler.sv
source/ctrl_sequencer.sv
source/ctrl_register_bank.sv
source/axi_ctrl_logic.sv
testbench/tb_axi_ctrl_logic.sv
